//--- src/ft245_pkg.sv
// FT245 bridge shared types
`default_nettype none

package ft245_pkg;

	// host word and chip bus widths
	localparam int word_width = 32;
	localparam int byte_width = 8;

	// each dual-clock FIFO holds 512 words
	localparam int fifo_addr_width = 9;

	// chip-side FSM states
	typedef enum logic [3:0] {
		idle,
		read_oe,
		read,
		wait_rd,
		delay1,
		write0,
		write1,
		write2,
		write3
	} phy_state_t;

	// status pins driven by the chip, both active low
	typedef struct packed {
		logic txe_n;
		logic rde_n;
	} ft_status_t;

	// strobes driven toward the chip, all active low
	typedef struct packed {
		logic wr_n;
		logic rd_n;
		logic oe_n;
	} ft_ctrl_t;

	// bytes[3] is the msb and goes first on the wire
	typedef union packed {
		logic [word_width-1:0] word;
		logic [3:0][byte_width-1:0] bytes;
	} word_bytes_u;

endpackage

`default_nettype wire

//--- src/afifo.sv
// Dual-clock word FIFO
`timescale 1ns/10ps
`default_nettype none

module afifo import ft245_pkg::*; (
	input logic rst,
	input logic din_clk,
	input logic dout_clk,

	// write side in din_clk domain
	input logic wr_en,
	input logic [word_width-1:0] data_in,
	output logic full,

	// read side in dout_clk domain
	input logic rd_en,
	output logic [word_width-1:0] data_out,
	output logic empty
);

	// storage has no reset
	logic [word_width-1:0] mem [0:(1 << fifo_addr_width)-1];

	// pointers carry one extra wrap bit
	logic [fifo_addr_width:0] wr_bin;
	logic [fifo_addr_width:0] wr_gray;
	logic [fifo_addr_width:0] wr_bin_next;
	logic [fifo_addr_width:0] wr_gray_next;
	logic [fifo_addr_width:0] rd_bin;
	logic [fifo_addr_width:0] rd_gray;
	logic [fifo_addr_width:0] rd_bin_next;
	logic [fifo_addr_width:0] rd_gray_next;

	// read pointer seen in the write domain
	logic [fifo_addr_width:0] rd_gray_s1;
	logic [fifo_addr_width:0] rd_gray_s2;

	// write pointer seen in the read domain
	logic [fifo_addr_width:0] wr_gray_s1;
	logic [fifo_addr_width:0] wr_gray_s2;

	logic wr_ok;
	logic rd_ok;

	// a push while full or a pop while empty is ignored
	assign wr_ok = wr_en & ~full;
	assign rd_ok = rd_en & ~empty;

	assign wr_bin_next = wr_bin + {{fifo_addr_width{1'b0}}, wr_ok};
	assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;
	assign rd_bin_next = rd_bin + {{fifo_addr_width{1'b0}}, rd_ok};
	assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

	// full when write has lapped read by one whole depth
	// gray form flips the two top bits for that case
	assign full = (wr_gray == {~rd_gray_s2[fifo_addr_width:fifo_addr_width-1],
		rd_gray_s2[fifo_addr_width-2:0]});

	// empty when read has caught the synchronized write pointer
	assign empty = (rd_gray == wr_gray_s2);

	// write domain pointers
	always_ff @(posedge din_clk) begin
		if (rst) begin
			wr_bin <= '0;
			wr_gray <= '0;
		end
		else begin
			wr_bin <= wr_bin_next;
			wr_gray <= wr_gray_next;
		end
	end

	// read pointer crossing into din_clk
	always_ff @(posedge din_clk) begin
		if (rst) begin
			rd_gray_s1 <= '0;
			rd_gray_s2 <= '0;
		end
		else begin
			rd_gray_s1 <= rd_gray;
			rd_gray_s2 <= rd_gray_s1;
		end
	end

	// memory write port
	always_ff @(posedge din_clk) begin
		if (wr_ok) begin
			mem[wr_bin[fifo_addr_width-1:0]] <= data_in;
		end
	end

	// read domain pointers
	always_ff @(posedge dout_clk) begin
		if (rst) begin
			rd_bin <= '0;
			rd_gray <= '0;
		end
		else begin
			rd_bin <= rd_bin_next;
			rd_gray <= rd_gray_next;
		end
	end

	// write pointer crossing into dout_clk
	always_ff @(posedge dout_clk) begin
		if (rst) begin
			wr_gray_s1 <= '0;
			wr_gray_s2 <= '0;
		end
		else begin
			wr_gray_s1 <= wr_gray;
			wr_gray_s2 <= wr_gray_s1;
		end
	end

	// registered read port
	// word is valid the cycle after the pop
	always_ff @(posedge dout_clk) begin
		if (rd_ok) begin
			data_out <= mem[rd_bin[fifo_addr_width-1:0]];
		end
	end

endmodule

`default_nettype wire

//--- src/ft245_phy.sv
// FT245 chip-side burst FSM
`timescale 1ns/10ps
`default_nettype none

module ft245_phy import ft245_pkg::*; (
	input logic ftdi_clk,
	input logic rst,

	// chip pins
	input ft_status_t status,
	output ft_ctrl_t ctrl,
	input logic [byte_width-1:0] rx_byte,
	output logic [byte_width-1:0] tx_byte,

	// inbound FIFO write side
	output logic in_wr,
	output logic [word_width-1:0] in_word,
	input logic in_full,

	// outbound FIFO read side
	output logic out_rd,
	input logic [word_width-1:0] out_word,
	input logic out_empty
);

	phy_state_t state;

	// position of the next byte within the word being packed
	logic [1:0] byte_cnt;

	// word being assembled from the chip
	word_bytes_u rx_pack;

	// word being sent to the chip
	word_bytes_u tx_word;

	logic word_done;

	assign tx_word = word_bytes_u'(out_word);

	// packed word stays put during the cycle in_wr is high
	assign in_word = rx_pack.word;

	// fourth byte of an aligned group is being taken this cycle
	assign word_done = (state == read) && !status.rde_n && (byte_cnt == 2'd3);

	// byte shift register
	// first byte ends up in bytes[3]
	always_ff @(posedge ftdi_clk) begin
		if (state == read && !status.rde_n) begin
			rx_pack.bytes <= {rx_pack.bytes[2:0], rx_byte};
		end
	end

	always_ff @(posedge ftdi_clk) begin
		if (rst) begin
			state <= idle;
			ctrl.wr_n <= 1'b1;
			ctrl.rd_n <= 1'b1;
			ctrl.oe_n <= 1'b1;
			tx_byte <= '0;
			byte_cnt <= 2'd0;
			in_wr <= 1'b0;
			out_rd <= 1'b0;
		end
		else begin
			// FIFO strobes last one cycle
			// a finished word is dropped if the inbound FIFO is full
			in_wr <= word_done & ~in_full;
			out_rd <= 1'b0;

			case (state)
				idle: begin
					ctrl.wr_n <= 1'b1;
					ctrl.rd_n <= 1'b1;
					ctrl.oe_n <= 1'b1;
					tx_byte <= '0;
					byte_cnt <= 2'd0;
					// reading takes priority over writing
					if (!status.rde_n) begin
						ctrl.oe_n <= 1'b0;
						state <= read_oe;
					end
					else if (!status.txe_n && !out_empty) begin
						out_rd <= 1'b1;
						state <= delay1;
					end
				end

				read_oe: begin
					// chip wants one cycle of oe_n before rd_n
					ctrl.rd_n <= 1'b0;
					state <= read;
				end

				read: begin
					if (status.rde_n) begin
						// burst over so release the bus
						// any partial word is thrown away
						ctrl.oe_n <= 1'b1;
						ctrl.rd_n <= 1'b1;
						byte_cnt <= 2'd0;
						state <= wait_rd;
					end
					else begin
						byte_cnt <= byte_cnt + 2'd1;
					end
				end

				wait_rd: begin
					// drain the chip until it reports empty
					ctrl.rd_n <= 1'b0;
					if (status.rde_n) begin
						ctrl.rd_n <= 1'b1;
						state <= idle;
					end
				end

				delay1: begin
					// popped word lands on out_word at this edge
					state <= write0;
				end

				write0: begin
					tx_byte <= tx_word.bytes[3];
					ctrl.wr_n <= 1'b1;
					if (!status.txe_n) begin
						ctrl.wr_n <= 1'b0;
						state <= write1;
					end
				end

				write1: begin
					tx_byte <= tx_word.bytes[2];
					ctrl.wr_n <= 1'b1;
					if (!status.txe_n) begin
						ctrl.wr_n <= 1'b0;
						state <= write2;
					end
				end

				write2: begin
					tx_byte <= tx_word.bytes[1];
					ctrl.wr_n <= 1'b1;
					if (!status.txe_n) begin
						ctrl.wr_n <= 1'b0;
						state <= write3;
					end
				end

				write3: begin
					// last byte then idle raises wr_n
					tx_byte <= tx_word.bytes[0];
					ctrl.wr_n <= 1'b1;
					if (!status.txe_n) begin
						ctrl.wr_n <= 1'b0;
						state <= idle;
					end
				end

				default: begin
					state <= idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/ft245_sync_fifo.sv
// FT245 synchronous FIFO bridge
`timescale 1ns/10ps
`default_nettype none

module ft245_sync_fifo import ft245_pkg::*; (
	// host side
	input logic clk,
	input logic rst,

	// words read from the chip toward the host
	input logic in_fifo_rst,
	input logic in_fifo_rd,
	output logic in_fifo_empty,
	output logic [word_width-1:0] in_fifo_data,

	// words from the host toward the chip
	input logic out_fifo_wr,
	output logic out_fifo_full,
	input logic [word_width-1:0] out_fifo_data,

	// chip side
	input logic ftdi_clk,
	inout wire [byte_width-1:0] ftdi_data,
	input ft_status_t ftdi_status,
	output ft_ctrl_t ftdi_ctrl
);

	// phy to inbound FIFO
	logic in_wr;
	logic in_full;
	logic [word_width-1:0] in_word;

	// outbound FIFO to phy
	logic out_rd;
	logic out_empty;
	logic [word_width-1:0] out_word;

	// bus values in each direction
	logic [byte_width-1:0] tx_byte;
	logic [byte_width-1:0] rx_byte;

	// drive the bus only while the chip has oe_n high
	assign ftdi_data = ftdi_ctrl.oe_n ? tx_byte : {byte_width{1'bz}};
	assign rx_byte = ftdi_data;

	// chip to host
	// cleared by the host's own reset pulse
	afifo fifo_in (
		.rst(in_fifo_rst),
		.din_clk(ftdi_clk),
		.dout_clk(clk),
		.wr_en(in_wr),
		.data_in(in_word),
		.full(in_full),
		.rd_en(in_fifo_rd),
		.data_out(in_fifo_data),
		.empty(in_fifo_empty)
	);

	// host to chip
	afifo fifo_out (
		.rst(rst),
		.din_clk(clk),
		.dout_clk(ftdi_clk),
		.wr_en(out_fifo_wr),
		.data_in(out_fifo_data),
		.full(out_fifo_full),
		.rd_en(out_rd),
		.data_out(out_word),
		.empty(out_empty)
	);

	ft245_phy u_phy (
		.ftdi_clk(ftdi_clk),
		.rst(rst),
		.status(ftdi_status),
		.ctrl(ftdi_ctrl),
		.rx_byte(rx_byte),
		.tx_byte(tx_byte),
		.in_wr(in_wr),
		.in_word(in_word),
		.in_full(in_full),
		.out_rd(out_rd),
		.out_word(out_word),
		.out_empty(out_empty)
	);

endmodule

`default_nettype wire

//--- verif/ft245_checker.sv
// FT245 bridge checker
`timescale 1ns/10ps
`default_nettype none

module ft245_checker import ft245_pkg::*; (
	input logic clk,
	input logic ftdi_clk,
	input logic rst,
	input logic in_fifo_rst,
	input logic in_fifo_rd,
	input logic in_fifo_empty,
	input logic [word_width-1:0] in_fifo_data,
	input ft_ctrl_t ftdi_ctrl,
	input wire [byte_width-1:0] ftdi_data,
	input phy_state_t phy_state
);

	// expected traffic in arrival order
	logic [byte_width-1:0] exp_chip[$];
	logic [word_width-1:0] exp_host[$];
	logic [byte_width-1:0] exp_byte;
	logic [word_width-1:0] exp_word;

	int value_errors = 0;
	int other_errors = 0;
	int chip_bytes = 0;
	int chip_words = 0;

	// a pop was accepted so data shows up next cycle
	logic pop_pending = 1'b0;

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			value_errors = value_errors + 1;
			$display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic report_error(input string msg);
		other_errors = other_errors + 1;
		$display("Error at %0t: %s (phy state %0d)", $time, msg, phy_state);
	endtask

	// msb goes out first
	task automatic expect_chip_word(input logic [word_width-1:0] w);
		exp_chip.push_back(w[31:24]);
		exp_chip.push_back(w[23:16]);
		exp_chip.push_back(w[15:8]);
		exp_chip.push_back(w[7:0]);
		chip_words = chip_words + 1;
	endtask

	task automatic expect_host_word(input logic [word_width-1:0] w);
		exp_host.push_back(w);
	endtask

	// words lost to an inbound reset are no longer owed
	task automatic clear_host();
		exp_host.delete();
	endtask

	function automatic int pending_count();
		return exp_chip.size() + exp_host.size();
	endfunction

	task automatic final_count_check();
		if (chip_bytes != 4 * chip_words) begin
			report_error($sformatf("chip took %0d bytes for %0d host words",
				chip_bytes, chip_words));
		end
	endtask

	// host side pops
	always @(posedge clk) begin
		if (rst || in_fifo_rst) begin
			pop_pending <= 1'b0;
		end
		else begin
			if (pop_pending) begin
				if (exp_host.size() == 0) begin
					report_error("host got a word that no vector sent");
				end
				else begin
					exp_word = exp_host.pop_front();
					check_value("in_fifo_data", exp_word, in_fifo_data);
				end
			end
			pop_pending <= in_fifo_rd && !in_fifo_empty;
		end
	end

	// chip takes a byte on every edge with wr_n low
	always @(posedge ftdi_clk) begin
		if (!rst && ftdi_ctrl.wr_n === 1'b0) begin
			chip_bytes = chip_bytes + 1;
			if (exp_chip.size() == 0) begin
				report_error("chip got a byte that no vector sent");
			end
			else begin
				exp_byte = exp_chip.pop_front();
				check_value("ftdi_data", exp_byte, ftdi_data);
			end
		end
	end

endmodule

`default_nettype wire

//--- verif/tb_ft245.sv
// FT245 bridge testbench
`timescale 1ns/10ps
`default_nettype none

module tb_ft245 import ft245_pkg::*; ();

	logic ftdi_clk = 1'b0;
	logic clk = 1'b0;
	logic rst;
	logic in_fifo_rst;
	logic in_fifo_rd;
	logic in_fifo_empty;
	logic [word_width-1:0] in_fifo_data;
	logic out_fifo_wr;
	logic out_fifo_full;
	logic [word_width-1:0] out_fifo_data;
	wire [byte_width-1:0] ftdi_data;
	ft_status_t ftdi_status;
	ft_ctrl_t ftdi_ctrl;

	// chip model queue entries are {last of burst, byte}
	logic txe_n;
	logic rde_n;
	logic [byte_width-1:0] chip_byte;
	logic [byte_width:0] chip_q[$];
	logic [byte_width:0] chip_ent;
	logic [31:0] rnd = 32'h1e7222fc;
	int gap;

	// three entries per vector line
	logic [31:0] vec [0:191];
	int idx;
	logic host_hold;
	logic stop;

	always #2 ftdi_clk = ~ftdi_clk;
	always #3 clk = ~clk;

	assign ftdi_status = {txe_n, rde_n};
	// chip owns the bus while oe_n is low
	assign ftdi_data = ftdi_ctrl.oe_n ? {byte_width{1'bz}} : chip_byte;

	ft245_sync_fifo u_dut (
		.clk(clk),
		.rst(rst),
		.in_fifo_rst(in_fifo_rst),
		.in_fifo_rd(in_fifo_rd),
		.in_fifo_empty(in_fifo_empty),
		.in_fifo_data(in_fifo_data),
		.out_fifo_wr(out_fifo_wr),
		.out_fifo_full(out_fifo_full),
		.out_fifo_data(out_fifo_data),
		.ftdi_clk(ftdi_clk),
		.ftdi_data(ftdi_data),
		.ftdi_status(ftdi_status),
		.ftdi_ctrl(ftdi_ctrl)
	);

	ft245_checker u_chk (
		.clk(clk),
		.ftdi_clk(ftdi_clk),
		.rst(rst),
		.in_fifo_rst(in_fifo_rst),
		.in_fifo_rd(in_fifo_rd),
		.in_fifo_empty(in_fifo_empty),
		.in_fifo_data(in_fifo_data),
		.ftdi_ctrl(ftdi_ctrl),
		.ftdi_data(ftdi_data),
		.phy_state(u_dut.u_phy.state)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// chip model
	// head byte sits on the bus and is popped on each rd_n low with oe_n low
	always @(posedge ftdi_clk) begin
		if (rst) begin
			rde_n <= 1'b1;
			txe_n <= 1'b1;
			gap = 0;
		end
		else begin
			if (!rde_n && !ftdi_ctrl.rd_n && !ftdi_ctrl.oe_n) begin
				chip_ent = chip_q.pop_front();
				// hold rde_n high long enough for the phy to get back to idle
				if (chip_ent[byte_width] || chip_q.size() == 0) begin
					gap = 4;
				end
			end
			else if (gap != 0) begin
				gap = gap - 1;
			end
			rde_n <= (gap != 0) || (chip_q.size() == 0);
			chip_byte <= (chip_q.size() != 0) ? chip_q[0][byte_width-1:0] : '0;
			// roughly one stall cycle in four
			rnd = xorshift(rnd);
			txe_n <= (rnd[1:0] == 2'b00);
		end
	end

	// host pops whenever a word is waiting
	always @(posedge clk) begin
		if (rst) begin
			in_fifo_rd <= 1'b0;
		end
		else begin
			in_fifo_rd <= !in_fifo_empty && !host_hold;
		end
	end

	task automatic push_host_word(input logic [31:0] w);
		@(negedge ftdi_clk);
		u_chk.expect_chip_word(w);
		// the host queues far fewer words than the FIFO holds
		u_chk.check_value("out_fifo_full", 0, out_fifo_full);
		@(posedge clk);
		out_fifo_wr <= 1'b1;
		out_fifo_data <= w;
		@(posedge clk);
		out_fifo_wr <= 1'b0;
	endtask

	// flag 1 ends the burst and 2..4 add stray bytes before the end
	task automatic queue_chip_word(input logic [31:0] w, input logic [31:0] flag);
		word_bytes_u wb;
		int k;
		wb.word = w;
		@(negedge ftdi_clk);
		u_chk.expect_host_word(w);
		for (k = 3; k >= 0; k--) begin
			chip_q.push_back({(k == 0 && flag == 1), wb.bytes[k]});
		end
		for (k = 1; k < flag; k++) begin
			chip_q.push_back({(k == flag - 1), 8'hc0 + k[7:0]});
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while ((u_chk.pending_count() != 0 || chip_q.size() != 0) && n < 4000) begin
			@(negedge ftdi_clk);
			n++;
		end
		if (n >= 4000) begin
			u_chk.report_error("expected traffic never drained");
			stop = 1'b1;
		end
	endtask

	task automatic wait_chip_empty();
		int n;
		n = 0;
		while ((chip_q.size() != 0 || !rde_n) && n < 400) begin
			@(negedge ftdi_clk);
			n++;
		end
		if (n >= 400) begin
			u_chk.report_error("chip model never emptied its read queue");
			stop = 1'b1;
		end
	endtask

	task automatic wait_word_waiting();
		int n;
		n = 0;
		while (in_fifo_empty && n < 50) begin
			@(negedge clk);
			n++;
		end
		if (n >= 50) begin
			u_chk.report_error("inbound FIFO never showed the held word");
			stop = 1'b1;
		end
	endtask

	// hold the host, fill the inbound FIFO, then clear it
	task automatic inbound_reset_check(input logic [31:0] w, input logic [31:0] flag);
		wait_drain();
		if (!stop) begin
			@(negedge ftdi_clk);
			host_hold = 1'b1;
			queue_chip_word(w, flag);
			wait_chip_empty();
		end
		if (!stop) begin
			wait_word_waiting();
		end
		if (!stop) begin
			@(posedge clk);
			in_fifo_rst <= 1'b1;
			repeat (3) @(posedge clk);
			in_fifo_rst <= 1'b0;
			repeat (2) @(negedge clk);
			u_chk.check_value("in_fifo_empty", 1, in_fifo_empty);
			u_chk.clear_host();
			host_hold = 1'b0;
		end
	endtask

	task automatic end_run();
		$display("errors: %0d value, %0d other", u_chk.value_errors, u_chk.other_errors);
		if (u_chk.value_errors == 0 && u_chk.other_errors == 0) begin
			$display("STATUS: PASS");
		end
		else begin
			$display("STATUS: FAIL");
		end
		$finish;
	endtask

	initial begin
		rst = 1'b1;
		in_fifo_rst = 1'b1;
		in_fifo_rd = 1'b0;
		out_fifo_wr = 1'b0;
		out_fifo_data = '0;
		txe_n = 1'b1;
		rde_n = 1'b1;
		chip_byte = '0;
		gap = 0;
		host_hold = 1'b0;
		stop = 1'b0;
		$readmemh("verif/ft245_vectors.txt", vec);
		repeat (2) @(posedge ftdi_clk);
		rst <= 1'b0;
		in_fifo_rst <= 1'b0;
		// quiet bus after reset
		repeat (6) begin
			@(negedge ftdi_clk);
			u_chk.check_value("ftdi_ctrl", 3'b111, ftdi_ctrl);
			u_chk.check_value("in_fifo_empty", 1, in_fifo_empty);
			u_chk.check_value("out_fifo_full", 0, out_fifo_full);
		end
		idx = 0;
		while (!stop && idx < 189 && vec[idx] !== 32'hf) begin
			case (vec[idx])
				0: push_host_word(vec[idx+1]);
				1: queue_chip_word(vec[idx+1], vec[idx+2]);
				2: inbound_reset_check(vec[idx+1], vec[idx+2]);
				default: begin
					u_chk.report_error("vector file holds an unknown direction code");
					stop = 1'b1;
				end
			endcase
			idx = idx + 3;
		end
		if (!stop) begin
			wait_drain();
		end
		if (!stop) begin
			u_chk.final_count_check();
		end
		end_run();
	end

endmodule

`default_nettype wire

//--- compile.f
src/ft245_pkg.sv
src/afifo.sv
src/ft245_phy.sv
src/ft245_sync_fifo.sv
verif/ft245_checker.sv
verif/tb_ft245.sv

//--- verif/ft245_vectors.txt
// columns: direction (0 host to chip, 1 chip to host, 2 chip to host then inbound reset, f end)
// then the 32-bit word, then flag (0 burst goes on, 1 burst ends, 2..4 add 1..3 stray bytes)
0 11223344 0
0 a5a55a5a 0
1 01020304 0
1 deadbeef 1
0 cafef00d 0
1 13579bdf 2
1 2468ace0 0
1 0f1e2d3c 4
0 89abcdef 0
0 00ff00ff 0
0 76543210 0
2 badc0ffe 3
1 55aa33cc 1
1 fedcba98 0
1 c3c3a5a5 3
0 12345678 0
1 9abcdef0 1
2 0badf00d 1
1 600dcafe 2
f 00000000 0
